// File: Bender.yml
package:
  name: dbg_subsystem

sources:
  - common/dbg_pkg.sv
  - hdl/dbg_ring_injector.sv
  - hdl/dbg_ring_collector.sv
  - dbg_ring/dbg_reg_endpoint.sv
  - dbg_ring/dbg_ring_node.sv
  - hdl/dbg_subsystem_top.sv
  - target: test
    files:
      - testbench/dbg_subsystem_assertions.sv
      - testbench/tb_dbg_subsystem.sv

// File: common/dbg_pkg.sv
package dbg_pkg;

   // One host word or one ring flit payload
   typedef logic [15:0] flit_data_t;

   // Address of a ring participant
   typedef logic [15:0] dbg_addr_t;

   // Debug ring flit as it travels between ring stops
   typedef struct packed {
      flit_data_t data;
      logic       last;
      logic       valid;
   } dii_flit_t;

   // Host sits at address zero
   localparam dbg_addr_t DBG_HOST_ADDR = 16'h0000;

   // Packet type codes, carried in the third flit
   localparam flit_data_t DBG_TYPE_REG_READ       = 16'd1;
   localparam flit_data_t DBG_TYPE_REG_WRITE      = 16'd2;
   localparam flit_data_t DBG_TYPE_REG_READ_RESP  = 16'd3;
   localparam flit_data_t DBG_TYPE_REG_WRITE_RESP = 16'd4;

   // Module type reported in register 1
   localparam flit_data_t DBG_MOD_TYPE_SCRATCH = 16'h0005;

   // Flit positions within a packet
   localparam int DBG_FLIT_DEST = 0;
   localparam int DBG_FLIT_SRC  = 1;
   localparam int DBG_FLIT_TYPE = 2;
   localparam int DBG_FLIT_ADDR = 3;
   localparam int DBG_FLIT_DATA = 4;

   // Longest packet the collector keeps
   localparam int DBG_MAX_PKT_LEN = 8;

endpackage

// File: dbg_ring/dbg_reg_endpoint.sv
`timescale 1ns/1ps

module dbg_reg_endpoint import dbg_pkg::*; #(
   parameter dbg_addr_t NODE_ID = 16'd1
) (
   input  logic      clk,
   input  logic      rst_i,

   input  dii_flit_t req_i,
   output logic      req_ready_o,

   output dii_flit_t resp_o,
   input  logic      resp_ready_i
);

   typedef enum logic [1:0] {
      RECV,
      RESPOND,
      DROP
   } ep_state_e;

   ep_state_e  state_q;
   logic [2:0] idx_q;
   logic [1:0] resp_idx_q;
   dbg_addr_t  src_q;
   flit_data_t type_q;
   flit_data_t addr_q;
   flit_data_t scratch_q [2];
   flit_data_t rdata;
   flit_data_t resp_type;
   logic       req_accept;
   logic       resp_accept;
   logic       type_ok;
   logic       wr_data;

   assign req_ready_o = (state_q != RESPOND);
   assign req_accept  = req_i.valid && req_ready_o;
   assign resp_accept = resp_o.valid && resp_ready_i;

   assign type_ok = (req_i.data == DBG_TYPE_REG_READ) || (req_i.data == DBG_TYPE_REG_WRITE);

   // Data flit of a write request
   assign wr_data = (state_q == RECV) && req_accept && (idx_q == 3'(DBG_FLIT_DATA)) &&
                    (type_q == DBG_TYPE_REG_WRITE);

   always_comb begin
      case (addr_q)
         16'd0:   rdata = NODE_ID;
         16'd1:   rdata = DBG_MOD_TYPE_SCRATCH;
         16'd2:   rdata = scratch_q[0];
         16'd3:   rdata = scratch_q[1];
         default: rdata = '0;
      endcase
   end

   assign resp_type = (type_q == DBG_TYPE_REG_READ) ? DBG_TYPE_REG_READ_RESP :
                                                      DBG_TYPE_REG_WRITE_RESP;

   // Response goes back to whoever sent the request
   always_comb begin
      resp_o.valid = (state_q == RESPOND);
      resp_o.last  = (resp_idx_q == 2'd3);
      case (resp_idx_q)
         2'd0:    resp_o.data = src_q;
         2'd1:    resp_o.data = NODE_ID;
         2'd2:    resp_o.data = resp_type;
         default: resp_o.data = rdata;
      endcase
   end

   always_ff @(posedge clk) begin
      if ((state_q == RECV) && req_accept) begin
         case (idx_q)
            3'(DBG_FLIT_SRC):  src_q  <= req_i.data;
            3'(DBG_FLIT_TYPE): type_q <= req_i.data;
            3'(DBG_FLIT_ADDR): addr_q <= req_i.data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q      <= RECV;
         idx_q        <= '0;
         resp_idx_q   <= '0;
         scratch_q[0] <= '0;
         scratch_q[1] <= '0;
      end else begin
         // Only the scratch registers take writes
         if (wr_data && (addr_q == 16'd2)) begin
            scratch_q[0] <= req_i.data;
         end
         if (wr_data && (addr_q == 16'd3)) begin
            scratch_q[1] <= req_i.data;
         end

         case (state_q)
            RECV: begin
               if (req_accept) begin
                  if (req_i.last) begin
                     idx_q <= '0;
                     // Too short to carry an address, consumed silently
                     if (idx_q >= 3'(DBG_FLIT_ADDR)) begin
                        state_q <= RESPOND;
                     end
                  end else begin
                     if (idx_q != 3'd7) begin
                        idx_q <= idx_q + 3'd1;
                     end
                     if ((idx_q == 3'(DBG_FLIT_TYPE)) && !type_ok) begin
                        state_q <= DROP;
                     end
                  end
               end
            end
            RESPOND: begin
               if (resp_accept) begin
                  resp_idx_q <= resp_idx_q + 2'd1;
                  if (resp_o.last) begin
                     state_q <= RECV;
                  end
               end
            end
            DROP: begin
               // Unknown type, swallow the rest of the packet
               if (req_accept && req_i.last) begin
                  idx_q   <= '0;
                  state_q <= RECV;
               end
            end
            default: begin
               state_q <= RECV;
            end
         endcase
      end
   end

endmodule

// File: dbg_ring/dbg_ring_node.sv
`timescale 1ns/1ps

module dbg_ring_node import dbg_pkg::*; #(
   parameter dbg_addr_t NODE_ID = 16'd1
) (
   input  logic      clk,
   input  logic      rst_i,

   input  dii_flit_t ring_i,
   output logic      ring_ready_o,

   output dii_flit_t ring_o,
   input  logic      ring_ready_i
);

   dii_flit_t out_q;
   dii_flit_t ep_req;
   dii_flit_t ep_resp;
   logic      ep_req_ready;
   logic      ep_resp_ready;
   logic      in_first_q;
   logic      route_local_q;
   logic      route_local;
   logic      local_q;
   logic      grant_local;
   logic      out_free;
   logic      pass_accept;
   logic      resp_accept;

   // Routing is decided on the destination flit and kept until last
   assign route_local = in_first_q ? (ring_i.data == NODE_ID) : route_local_q;

   assign out_free = !out_q.valid || ring_ready_i;

   // Local response may only start between passing packets
   assign grant_local = local_q || (ep_resp.valid && (in_first_q || route_local_q));

   assign ring_ready_o = !grant_local && (route_local ? ep_req_ready : out_free);
   assign pass_accept  = ring_i.valid && ring_ready_o && !route_local;

   assign ep_req.data  = ring_i.data;
   assign ep_req.last  = ring_i.last;
   assign ep_req.valid = ring_i.valid && route_local && !grant_local;

   assign ep_resp_ready = grant_local && out_free;
   assign resp_accept   = ep_resp.valid && ep_resp_ready;

   assign ring_o = out_q;

   dbg_reg_endpoint #(
      .NODE_ID (NODE_ID)
   ) i_endpoint (
      .clk          (clk),
      .rst_i        (rst_i),
      .req_i        (ep_req),
      .req_ready_o  (ep_req_ready),
      .resp_o       (ep_resp),
      .resp_ready_i (ep_resp_ready)
   );

   always_ff @(posedge clk) begin
      if (rst_i) begin
         out_q.valid   <= 1'b0;
         in_first_q    <= 1'b1;
         route_local_q <= 1'b0;
         local_q       <= 1'b0;
      end else begin
         if (ring_i.valid && ring_ready_o) begin
            in_first_q    <= ring_i.last;
            route_local_q <= route_local;
         end

         // Hold the grant until the response's last flit is out
         if (resp_accept) begin
            local_q <= !ep_resp.last;
         end

         if (out_free) begin
            if (resp_accept) begin
               out_q <= ep_resp;
            end else if (pass_accept) begin
               out_q <= ring_i;
            end else begin
               out_q.valid <= 1'b0;
            end
         end
      end
   end

endmodule

// File: hdl/dbg_ring_collector.sv
`timescale 1ns/1ps

module dbg_ring_collector import dbg_pkg::*; #(
   parameter int MAX_PKT_LEN = 8
) (
   input  logic       clk,
   input  logic       rst_i,

   input  dii_flit_t  ring_i,
   output logic       ring_ready_o,

   output flit_data_t host_out_data_o,
   output logic       host_out_valid_o,
   input  logic       host_out_ready_i
);

   localparam int CNT_W = $clog2(MAX_PKT_LEN + 1);
   localparam int IDX_W = $clog2(MAX_PKT_LEN);

   typedef enum logic [1:0] {
      COLLECT,
      SEND_LEN,
      SEND_FLITS
   } col_state_e;

   col_state_e       state_q;
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] rd_q;
   flit_data_t       pkt_buf [MAX_PKT_LEN];
   logic             store;

   // Ring is only accepted while the buffer is filling
   assign ring_ready_o = (state_q == COLLECT);

   // Flits beyond the buffer size are dropped
   assign store = ring_i.valid && ring_ready_o && (count_q < CNT_W'(MAX_PKT_LEN));

   assign host_out_valid_o = (state_q != COLLECT);

   always_comb begin
      if (state_q == SEND_LEN) begin
         host_out_data_o = flit_data_t'(count_q);
      end else begin
         host_out_data_o = pkt_buf[rd_q[IDX_W-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      if (store) begin
         pkt_buf[count_q[IDX_W-1:0]] <= ring_i.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= COLLECT;
         count_q <= '0;
         rd_q    <= '0;
      end else begin
         case (state_q)
            COLLECT: begin
               if (store) begin
                  count_q <= count_q + CNT_W'(1);
               end
               if (ring_i.valid && ring_i.last) begin
                  state_q <= SEND_LEN;
               end
            end
            SEND_LEN: begin
               if (host_out_ready_i) begin
                  rd_q    <= '0;
                  state_q <= SEND_FLITS;
               end
            end
            SEND_FLITS: begin
               if (host_out_ready_i) begin
                  if (rd_q == count_q - CNT_W'(1)) begin
                     count_q <= '0;
                     state_q <= COLLECT;
                  end else begin
                     rd_q <= rd_q + CNT_W'(1);
                  end
               end
            end
            default: begin
               state_q <= COLLECT;
            end
         endcase
      end
   end

endmodule

// File: hdl/dbg_ring_injector.sv
`timescale 1ns/1ps

module dbg_ring_injector import dbg_pkg::*; (
   input  logic       clk,
   input  logic       rst_i,

   input  flit_data_t host_in_data_i,
   input  logic       host_in_valid_i,
   output logic       host_in_ready_o,

   output dii_flit_t  ring_o,
   input  logic       ring_ready_i
);

   typedef enum logic {
      WAIT_COUNT,
      FORWARD
   } inj_state_e;

   inj_state_e state_q;
   flit_data_t remaining_q;
   dii_flit_t  flit_q;
   logic       accept;

   // Host is held off while the output flit waits on the ring
   assign host_in_ready_o = !flit_q.valid || ring_ready_i;
   assign accept          = host_in_valid_i && host_in_ready_o;
   assign ring_o          = flit_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q      <= WAIT_COUNT;
         remaining_q  <= '0;
         flit_q.valid <= 1'b0;
      end else begin
         if (ring_ready_i) begin
            flit_q.valid <= 1'b0;
         end

         if (accept) begin
            case (state_q)
               WAIT_COUNT: begin
                  // Empty packets are skipped
                  if (host_in_data_i != '0) begin
                     remaining_q <= host_in_data_i;
                     state_q     <= FORWARD;
                  end
               end
               FORWARD: begin
                  flit_q.data  <= host_in_data_i;
                  flit_q.last  <= (remaining_q == 16'd1);
                  flit_q.valid <= 1'b1;
                  remaining_q  <= remaining_q - 16'd1;
                  if (remaining_q == 16'd1) begin
                     state_q <= WAIT_COUNT;
                  end
               end
               default: begin
                  state_q <= WAIT_COUNT;
               end
            endcase
         end
      end
   end

endmodule

// File: hdl/dbg_subsystem_top.sv
`timescale 1ns/1ps

module dbg_subsystem_top import dbg_pkg::*; #(
   parameter int NUM_NODES = 3
) (
   input  logic       clk,
   input  logic       rst_i,

   input  flit_data_t host_in_data_i,
   input  logic       host_in_valid_i,
   output logic       host_in_ready_o,

   output flit_data_t host_out_data_o,
   output logic       host_out_valid_o,
   input  logic       host_out_ready_i
);

   // Link i feeds node i, link NUM_NODES feeds the collector
   dii_flit_t [NUM_NODES:0] ring_flit;
   logic      [NUM_NODES:0] ring_ready;

   dbg_ring_injector i_injector (
      .clk             (clk),
      .rst_i           (rst_i),
      .host_in_data_i  (host_in_data_i),
      .host_in_valid_i (host_in_valid_i),
      .host_in_ready_o (host_in_ready_o),
      .ring_o          (ring_flit[0]),
      .ring_ready_i    (ring_ready[0])
   );

   for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
      dbg_ring_node #(
         .NODE_ID (dbg_addr_t'(i + 1))
      ) i_node (
         .clk          (clk),
         .rst_i        (rst_i),
         .ring_i       (ring_flit[i]),
         .ring_ready_o (ring_ready[i]),
         .ring_o       (ring_flit[i+1]),
         .ring_ready_i (ring_ready[i+1])
      );
   end

   dbg_ring_collector #(
      .MAX_PKT_LEN (DBG_MAX_PKT_LEN)
   ) i_collector (
      .clk              (clk),
      .rst_i            (rst_i),
      .ring_i           (ring_flit[NUM_NODES]),
      .ring_ready_o     (ring_ready[NUM_NODES]),
      .host_out_data_o  (host_out_data_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i)
   );

endmodule

// File: testbench/dbg_subsystem_assertions.sv
`timescale 1ns/1ps

module dbg_subsystem_assertions import dbg_pkg::*; #(
   parameter int NUM_NODES = 3
) (
   input logic                    clk,
   input logic                    rst_i,
   input dii_flit_t [NUM_NODES:0] ring_flit_i,
   input logic                    inj_ready_i,
   input flit_data_t              host_out_data_i,
   input logic                    host_out_valid_i,
   input logic                    host_out_ready_i
);

   int unsigned fail_count = 0;
   logic        any_valid;

   always_comb begin
      any_valid = host_out_valid_i;
      for (int i = 0; i <= NUM_NODES; i++) begin
         any_valid = any_valid | ring_flit_i[i].valid;
      end
   end

   // Reply word holds while the host stalls
   assert property (@(posedge clk) disable iff (rst_i)
      (host_out_valid_i && !host_out_ready_i) |=> (host_out_valid_i && $stable(host_out_data_i)))
   else begin
      fail_count++;
      $error("host_out_data_o changed while stalled");
   end

   assert property (@(posedge clk) rst_i |=> !any_valid)
   else begin
      fail_count++;
      $error("Valid flit or host word right after reset");
   end

   // Stalled injector flit is held, no host word may replace it
   assert property (@(posedge clk) disable iff (rst_i)
      (ring_flit_i[0].valid && !inj_ready_i) |=> $stable(ring_flit_i[0]))
   else begin
      fail_count++;
      $error("Injector flit changed while stalled on the ring");
   end

endmodule

bind dbg_subsystem_top dbg_subsystem_assertions #(
   .NUM_NODES (NUM_NODES)
) i_assertions (
   .clk              (clk),
   .rst_i            (rst_i),
   .ring_flit_i      (ring_flit),
   .inj_ready_i      (ring_ready[0]),
   .host_out_data_i  (host_out_data_o),
   .host_out_valid_i (host_out_valid_o),
   .host_out_ready_i (host_out_ready_i)
);

// File: testbench/tb_dbg_subsystem.sv
`timescale 1ns/1ps

module tb_dbg_subsystem import dbg_pkg::*; ();

   localparam int NUM_NODES      = 3;
   // Two passes of 22 requests, the dropped type, its follow-up read, 6 reads after reset
   localparam int NUM_REQUESTS   = 52;
   localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 200;
   localparam int NO_REPLY_WAIT  = 50;

   localparam logic [1:0] KIND_COUNT = 2'd0;
   localparam logic [1:0] KIND_DEST  = 2'd1;
   localparam logic [1:0] KIND_SRC   = 2'd2;
   localparam logic [1:0] KIND_DATA  = 2'd3;

   typedef flit_data_t word_q_t [$];
   typedef flit_data_t [1:0] node_scratch_t;

   typedef struct packed {
      logic [1:0] kind;
      flit_data_t value;
   } exp_word_t;

   logic          clk;
   logic          rst_i;
   flit_data_t    host_in_data_i;
   logic          host_in_valid_i;
   logic          host_in_ready_o;
   flit_data_t    host_out_data_o;
   logic          host_out_valid_o;
   logic          host_out_ready_i;

   exp_word_t     exp_q [$];
   node_scratch_t scratch_model [1:NUM_NODES];
   logic [31:0]   rng_state;
   logic          random_ready;
   int            cycle_count = 0;

   dbg_subsystem_top #(
      .NUM_NODES (NUM_NODES)
   ) i_dbg_subsystem_top (
      .clk              (clk),
      .rst_i            (rst_i),
      .host_in_data_i   (host_in_data_i),
      .host_in_valid_i  (host_in_valid_i),
      .host_in_ready_o  (host_in_ready_o),
      .host_out_data_o  (host_out_data_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Host word stream the DUT should return for one request
   function automatic word_q_t expected_reply(input word_q_t pkt, input node_scratch_t regs);
      word_q_t    reply;
      dbg_addr_t  dest;
      flit_data_t value;
      dest = pkt[0];
      if ((dest < 1) || (dest > NUM_NODES)) begin
         // Nobody owns it, so it comes back as sent
         reply.push_back(flit_data_t'(pkt.size()));
         foreach (pkt[i]) begin
            reply.push_back(pkt[i]);
         end
      end else if ((pkt[2] == DBG_TYPE_REG_READ) || (pkt[2] == DBG_TYPE_REG_WRITE)) begin
         case (pkt[3])
            16'd0:   value = dest;
            16'd1:   value = DBG_MOD_TYPE_SCRATCH;
            16'd2:   value = regs[0];
            16'd3:   value = regs[1];
            default: value = '0;
         endcase
         if ((pkt[2] == DBG_TYPE_REG_WRITE) && ((pkt[3] == 16'd2) || (pkt[3] == 16'd3))) begin
            value = pkt[4];
         end
         reply.push_back(16'd4);
         reply.push_back(pkt[1]);
         reply.push_back(dest);
         reply.push_back((pkt[2] == DBG_TYPE_REG_READ) ? DBG_TYPE_REG_READ_RESP :
                                                         DBG_TYPE_REG_WRITE_RESP);
         reply.push_back(value);
      end
      return reply;
   endfunction

   task automatic check_word(input string name, input flit_data_t exp, input flit_data_t act);
      if (act !== exp) begin
         $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1, "Word mismatch on %s", name);
      end
   endtask

   task automatic check_addr(input string name, input dbg_addr_t exp, input dbg_addr_t act);
      if (act !== exp) begin
         $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1, "Address mismatch on %s", name);
      end
   endtask

   // Host output handshake completes on the rising edge
   always @(posedge clk) begin : compare
      exp_word_t e;
      if (!rst_i && host_out_valid_o && host_out_ready_i) begin
         if (exp_q.size() == 0) begin
            $display("Host sent word %h at %0t ns with no reply expected", host_out_data_o, $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "Unexpected host output word");
         end else begin
            e = exp_q.pop_front();
            case (e.kind)
               KIND_COUNT: check_word("host_out_data_o (count)", e.value, host_out_data_o);
               KIND_DEST:  check_addr("host_out_data_o (destination)", e.value, host_out_data_o);
               KIND_SRC:   check_addr("host_out_data_o (source)", e.value, host_out_data_o);
               default:    check_word("host_out_data_o (data)", e.value, host_out_data_o);
            endcase
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a reply never completed", cycle_count);
         $display("SOME TESTS FAILED");
         $fatal(1, "Simulation timeout");
      end
   end

   task automatic next_cycle();
      @(negedge clk);
      if (random_ready) begin
         rng_state        = xorshift32(rng_state);
         host_out_ready_i = rng_state[7];
      end else begin
         host_out_ready_i = 1'b1;
      end
   endtask

   task automatic apply_reset();
      rst_i           = 1'b1;
      host_in_valid_i = 1'b0;
      repeat (10) next_cycle();
      rst_i = 1'b0;
      for (int n = 1; n <= NUM_NODES; n++) begin
         scratch_model[n] = '0;
      end
   endtask

   // Count word first, then the flits
   task automatic send_packet(input word_q_t pkt);
      word_q_t words;
      words = {flit_data_t'(pkt.size()), pkt};
      foreach (words[i]) begin
         host_in_data_i  = words[i];
         host_in_valid_i = 1'b1;
         @(posedge clk);
         while (!host_in_ready_o) @(posedge clk);
         next_cycle();
      end
      host_in_valid_i = 1'b0;
   endtask

   task automatic run_request(input word_q_t pkt);
      word_q_t   reply;
      dbg_addr_t dest;
      exp_word_t e;
      dest = pkt[0];
      if ((dest >= 1) && (dest <= NUM_NODES)) begin
         reply = expected_reply(pkt, scratch_model[dest]);
      end else begin
         reply = expected_reply(pkt, '0);
      end
      foreach (reply[i]) begin
         e.kind  = (i == 0) ? KIND_COUNT : (i == 1) ? KIND_DEST : (i == 2) ? KIND_SRC : KIND_DATA;
         e.value = reply[i];
         exp_q.push_back(e);
      end
      send_packet(pkt);
      if (reply.size() == 0) begin
         // Give a stray reply time to reach the host and hit the compare
         repeat (NO_REPLY_WAIT) next_cycle();
      end
      while (exp_q.size() != 0) next_cycle();
      if ((dest >= 1) && (dest <= NUM_NODES) && (pkt[2] == DBG_TYPE_REG_WRITE) &&
          ((pkt[3] == 16'd2) || (pkt[3] == 16'd3))) begin
         scratch_model[dest][pkt[3][0]] = pkt[4];
      end
   endtask

   task automatic read_reg(input dbg_addr_t node, input flit_data_t addr);
      run_request({node, DBG_HOST_ADDR, DBG_TYPE_REG_READ, addr});
   endtask

   task automatic write_reg(input dbg_addr_t node, input flit_data_t addr);
      rng_state = xorshift32(rng_state);
      run_request({node, DBG_HOST_ADDR, DBG_TYPE_REG_WRITE, addr, rng_state[15:0]});
   endtask

   // ID and type reads, scratch traffic, read-only writes, unowned address
   task automatic run_behaviors();
      for (int n = 1; n <= NUM_NODES; n++) begin
         read_reg(n, 16'd0);
         read_reg(n, 16'd1);
      end
      for (int n = 1; n <= NUM_NODES; n++) begin
         write_reg(n, 16'd2);
         write_reg(n, 16'd3);
      end
      for (int n = 1; n <= NUM_NODES; n++) begin
         read_reg(n, 16'd2);
         read_reg(n, 16'd3);
      end
      write_reg(2, 16'd0);
      write_reg(2, 16'd7);
      read_reg(2, 16'd0);
      run_request({16'd9, DBG_HOST_ADDR, DBG_TYPE_REG_READ, 16'd1});
   endtask

   initial begin
      rst_i            = 1'b1;
      host_in_data_i   = '0;
      host_in_valid_i  = 1'b0;
      host_out_ready_i = 1'b1;
      random_ready     = 1'b0;
      rng_state        = 32'd93688;
      apply_reset();
      run_behaviors();
      // Unknown type 6 is swallowed by node 1
      run_request({16'd1, DBG_HOST_ADDR, 16'd6, 16'd2});
      read_reg(1, 16'd0);
      random_ready = 1'b1;
      run_behaviors();
      apply_reset();
      for (int n = 1; n <= NUM_NODES; n++) begin
         read_reg(n, 16'd2);
         read_reg(n, 16'd3);
      end
      random_ready = 1'b0;
      repeat (4) next_cycle();
      if (i_dbg_subsystem_top.i_assertions.fail_count == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("%0d assertion failures", i_dbg_subsystem_top.i_assertions.fail_count);
         $display("SOME TESTS FAILED");
         $fatal(1, "Assertion failures");
      end
   end

endmodule

// File: verilog.f
common/dbg_pkg.sv
hdl/dbg_ring_injector.sv
hdl/dbg_ring_collector.sv
dbg_ring/dbg_reg_endpoint.sv
dbg_ring/dbg_ring_node.sv
hdl/dbg_subsystem_top.sv
testbench/dbg_subsystem_assertions.sv
testbench/tb_dbg_subsystem.sv
